// ==== bench/tb_core.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_core;
  import isa_pkg::*;

  localparam int RESET_CYCLES   = 16;
  localparam int NUM_TESTS      = 6;
  localparam int TEST_CYCLES    = 400;
  localparam int MAX_PROG_WORDS = 64;
  // every test also holds reset while its program is written
  localparam int TIMEOUT_CYCLES =
    RESET_CYCLES + NUM_TESTS * (TEST_CYCLES + RESET_CYCLES + 2 * MAX_PROG_WORDS);

  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_IMM    = 7'h13;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam word_t      INSTR_EBREAK = 32'h0010_0073;

  logic                    clk_i = 1'b0;
  logic                    reset_i;
  logic [`CORE_MEM_AW-1:0] host_addr_i;
  logic [15:0]             host_data_i;
  logic                    host_we_i;
  logic [4:0]              dbg_addr_i;
  word_t                   dbg_data_o;
  logic                    halted_o;

  integer seed;
  int     cycle_count = 0;
  int     error_count;
  int     start_errors;
  int     pass_count;
  int     fail_count;
  word_t  prog [$];
  word_t  expected [32];

  rv_core_top i_dut (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_addr_i (host_addr_i),
    .host_data_i (host_data_i),
    .host_we_i   (host_we_i),
    .dbg_addr_i  (dbg_addr_i),
    .dbg_data_o  (dbg_data_o),
    .halted_o    (halted_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("timeout: core never halted within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // RV32I encodings built from the instruction formats
  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return i_type(imm, rs1, 3'b000, rd, OPC_IMM);
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic word_t b_type(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                   logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [20:0] off, logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  // reference results for the OP and OP-IMM groups
  function automatic word_t expected_op(logic [2:0] f3, logic alt, word_t x, word_t y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'b011:  return (x < y) ? 32'd1 : 32'd0;
      3'b100:  return x ^ y;
      3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  function automatic bit branch_taken(logic [2:0] f3, word_t x, word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic check_word(string what, word_t got, word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_reg(logic [4:0] idx, word_t exp);
    word_t got;
    next_cycle();
    dbg_addr_i = idx;
    #1;
    got = dbg_data_o;
    check_word($sformatf("x%0d", idx), got, exp);
  endtask

  task automatic check_regs(int lo, int hi);
    int i;
    for (i = lo; i <= hi; i++)
      check_reg(5'(i), expected[i]);
  endtask

  // lui plus a sign-extended addi rebuild any 32-bit constant
  task automatic load_const(logic [4:0] rd, word_t v);
    word_t upper;
    upper = v + 32'h800;
    prog.push_back(u_type(upper[31:12], rd, OPC_LUI));
    prog.push_back(addi(rd, rd, v[11:0]));
  endtask

  // program goes in through the host port while reset holds the core
  task automatic run_program();
    int i;
    int held;
    next_cycle();
    reset_i = 1'b1;
    held = 0;
    for (i = 0; i < 2 * prog.size(); i++) begin
      next_cycle();
      host_we_i   = 1'b1;
      host_addr_i = i[`CORE_MEM_AW-1:0];
      host_data_i = i[0] ? prog[i / 2][31:16] : prog[i / 2][15:0];
      held++;
    end
    next_cycle();
    host_we_i = 1'b0;
    held++;
    while (held < RESET_CYCLES) begin
      next_cycle();
      held++;
    end
    check_flag("halted_o after reset", halted_o, 1'b0);
    reset_i = 1'b0;
    prog.delete();
    while (!halted_o)
      next_cycle();
  endtask

  task automatic finish_test(string name);
    if (error_count == start_errors) begin
      $display("%s: ok", name);
      pass_count++;
    end else begin
      $display("%s: %0d errors", name, error_count - start_errors);
      fail_count++;
    end
    start_errors = error_count;
  endtask

  task automatic alu_ops_test();
    word_t       a;
    word_t       b;
    word_t       c_ext;
    word_t       y;
    logic [11:0] c;
    logic [11:0] imm;
    logic [4:0]  sh;
    logic [2:0]  f3;
    int          i;
    a = $random(seed);
    b = $random(seed);
    c = 12'($random(seed));
    sh = 5'($random(seed));
    c_ext = {{20{c[11]}}, c};
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (i = 0; i < 8; i++) begin
      f3 = 3'(i);
      prog.push_back(r_type(7'h00, 5'd2, 5'd1, f3, 5'(3 + i)));
      expected[3 + i] = expected_op(f3, 1'b0, a, b);
      // shift immediates carry only a shamt
      imm = (f3 == 3'b001 || f3 == 3'b101) ? {7'h00, sh} : c;
      y = (f3 == 3'b001 || f3 == 3'b101) ? word_t'(sh) : c_ext;
      prog.push_back(i_type(imm, 5'd1, f3, 5'(13 + i), OPC_IMM));
      expected[13 + i] = expected_op(f3, 1'b0, a, y);
    end
    prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd11));
    expected[11] = expected_op(3'b000, 1'b1, a, b);
    prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd12));
    expected[12] = expected_op(3'b101, 1'b1, a, b);
    prog.push_back(i_type({7'h20, sh}, 5'd1, 3'b101, 5'd21, OPC_IMM));
    expected[21] = expected_op(3'b101, 1'b1, a, word_t'(sh));
    // result aimed at x0 is dropped
    prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
    prog.push_back(INSTR_EBREAK);
    expected[0] = '0;
    expected[1] = a;
    expected[2] = b;
    run_program();
    check_regs(0, 21);
  endtask

  task automatic upper_imm_test();
    logic [19:0] u1;
    logic [19:0] u2;
    logic [19:0] u3;
    u1 = 20'($random(seed));
    u2 = 20'($random(seed));
    u3 = 20'($random(seed));
    prog.push_back(u_type(u1, 5'd1, OPC_LUI));
    prog.push_back(u_type(u2, 5'd2, OPC_AUIPC));
    prog.push_back(addi(5'd0, 5'd0, 12'd0));
    prog.push_back(u_type(u3, 5'd3, OPC_AUIPC));
    prog.push_back(INSTR_EBREAK);
    expected[1] = {u1, 12'h000};
    expected[2] = {u2, 12'h000} + 32'd4;
    expected[3] = {u3, 12'h000} + 32'd12;
    run_program();
    check_regs(1, 3);
  endtask

  // marker is 1 when the branch skipped the second addi and 2 when it fell through
  task automatic branch_test();
    word_t      vals [4];
    logic [2:0] f3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    int         f;
    int         p;
    vals[0] = '0;
    vals[1] = 32'hffff_fffb;
    vals[2] = 32'd7;
    vals[3] = 32'd7;
    prog.push_back(addi(5'd1, 5'd0, 12'hffb));
    prog.push_back(addi(5'd2, 5'd0, 12'd7));
    prog.push_back(addi(5'd3, 5'd0, 12'd7));
    for (f = 0; f < 6; f++) begin
      for (p = 0; p < 3; p++) begin
        f3 = (f < 2) ? 3'(f) : 3'(f + 2);
        rs1 = (p == 0) ? 5'd1 : 5'd2;
        rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
        rd = 5'(4 + 3 * f + p);
        prog.push_back(addi(rd, 5'd0, 12'd1));
        prog.push_back(b_type(13'd8, rs2, rs1, f3));
        prog.push_back(addi(rd, 5'd0, 12'd2));
        expected[rd] = branch_taken(f3, vals[rs1], vals[rs2]) ? 32'd1 : 32'd2;
      end
    end
    prog.push_back(INSTR_EBREAK);
    expected[1] = vals[1];
    expected[2] = vals[2];
    expected[3] = vals[3];
    run_program();
    check_regs(1, 21);
  endtask

  task automatic jump_test();
    prog.push_back(addi(5'd5, 5'd0, 12'd0));
    prog.push_back(addi(5'd7, 5'd0, 12'd0));
    // jal at 8 lands on 20
    prog.push_back(j_type(21'd12, 5'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd1));
    prog.push_back(addi(5'd5, 5'd0, 12'd1));
    prog.push_back(addi(5'd6, 5'd0, 12'd36));
    // jalr at 24 lands on 36 + 4
    prog.push_back(i_type(12'd4, 5'd6, 3'b000, 5'd2, OPC_JALR));
    prog.push_back(addi(5'd5, 5'd5, 12'd2));
    prog.push_back(addi(5'd5, 5'd5, 12'd4));
    prog.push_back(addi(5'd5, 5'd5, 12'd8));
    prog.push_back(addi(5'd7, 5'd0, 12'd77));
    prog.push_back(INSTR_EBREAK);
    run_program();
    check_reg(5'd1, 32'd12);
    check_reg(5'd2, 32'd28);
    check_reg(5'd5, 32'd0);
    check_reg(5'd6, 32'd36);
    check_reg(5'd7, 32'd77);
  endtask

  task automatic load_store_test();
    word_t       data [4];
    logic [11:0] offs [4];
    int          k;
    offs[0] = 12'h000;
    offs[1] = 12'h004;
    offs[2] = 12'h3fc;
    offs[3] = 12'hf00;
    prog.push_back(addi(5'd1, 5'd0, 12'h400));
    for (k = 0; k < 4; k++) begin
      data[k] = $random(seed);
      load_const(5'(10 + k), data[k]);
    end
    for (k = 0; k < 4; k++)
      prog.push_back(s_type(offs[k], 5'(10 + k), 5'd1));
    // read back in reverse order into other registers
    for (k = 3; k >= 0; k--) begin
      prog.push_back(i_type(offs[k], 5'd1, 3'b010, 5'(20 + k), OPC_LOAD));
      expected[20 + k] = data[k];
    end
    prog.push_back(INSTR_EBREAK);
    run_program();
    check_regs(20, 23);
  endtask

  task automatic rerun_test();
    logic [11:0] c;
    word_t       c_ext;
    c = 12'($random(seed));
    c_ext = {{20{c[11]}}, c};
    prog.push_back(addi(5'd20, 5'd0, c));
    prog.push_back(r_type(7'h00, 5'd20, 5'd20, 3'b000, 5'd21));
    prog.push_back(u_type(20'h00000, 5'd22, OPC_AUIPC));
    prog.push_back(INSTR_EBREAK);
    expected[20] = c_ext;
    expected[21] = c_ext + c_ext;
    expected[22] = 32'd8;
    run_program();
    check_regs(20, 22);
    check_flag("halted_o after second run", halted_o, 1'b1);
  endtask

  initial begin
    seed = 32'hf44;
    reset_i = 1'b1;
    host_addr_i = '0;
    host_data_i = '0;
    host_we_i = 1'b0;
    dbg_addr_i = '0;
    error_count = 0;
    start_errors = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (RESET_CYCLES) next_cycle();
    alu_ops_test();
    finish_test("alu ops");
    upper_imm_test();
    finish_test("lui and auipc");
    branch_test();
    finish_test("branches");
    jump_test();
    finish_test("jal and jalr");
    load_store_test();
    finish_test("sw and lw");
    rerun_test();
    finish_test("second program");
    $display("%0d tests ok, %0d with errors", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/ucode_pkg.sv
hdl/microcode_rom.sv
hdl/control_unit.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/halfword_mem.sv
hdl/rv_core_top.sv
bench/tb_core.sv

// ==== hdl/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  isa_pkg::alu_op_e    op_i,
  input  isa_pkg::word_t      a_i,
  input  isa_pkg::word_t      b_i,
  output isa_pkg::word_t      result_o,
  output isa_pkg::alu_flags_t flags_o
);
  import isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  // compare flags serve both slt and the branches
  assign flags_o.equal       = (a_i == b_i);
  assign flags_o.less        = (a_i < b_i);
  assign flags_o.less_signed = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = word_t'(flags_o.less_signed);
      ALU_SLTU: result_o = word_t'(flags_o.less);
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      default:  result_o = a_i & b_i;
    endcase
  end

endmodule

// ==== hdl/control_unit.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module control_unit (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  ucode_pkg::ctrl_word_t   ctrl_i,
  input  logic [15:0]             mem_data_i,
  output logic [`CORE_MEM_AW-1:0] mem_addr_o,
  output logic [15:0]             mem_data_o,
  output logic                    mem_we_o,
  output logic [4:0]              rs1_addr_o,
  output logic [4:0]              rs2_addr_o,
  output logic [4:0]              rd_addr_o,
  output logic                    rf_we_o,
  input  isa_pkg::word_t          rs1_i,
  input  isa_pkg::word_t          rs2_i,
  output isa_pkg::word_t          rd_data_o,
  output isa_pkg::alu_op_e        alu_op_o,
  output isa_pkg::word_t          alu_a_o,
  output isa_pkg::word_t          alu_b_o,
  input  isa_pkg::word_t          alu_result_i,
  input  isa_pkg::alu_flags_t     alu_flags_i,
  output logic                    halted_o
);
  import isa_pkg::*;
  import ucode_pkg::*;

  logic [31:0] ir_q;
  logic [15:0] tmp_q;
  word_t       pc_q;
  logic        halted_q;
  instr_u      instr;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_b;
  word_t       imm_j;
  word_t       imm_u;
  word_t       pc_plus4;
  word_t       ld_addr;
  word_t       st_addr;
  word_t       base_addr;
  word_t       byte_addr;
  word_t       pc_next;
  logic        taken;
  pc_sel_e     pc_sel;

  // forward the upper halfword on the step that latches it
  assign instr = ctrl_i.ir_hi_we ? {mem_data_i, ir_q[15:0]} : ir_q;

  assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
  assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
  assign imm_b = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                  instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
  assign imm_j = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                  instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
  assign imm_u = {instr.u_fmt.imm, 12'h000};

  assign rs1_addr_o = instr.r_fmt.rs1;
  assign rs2_addr_o = instr.r_fmt.rs2;
  assign rd_addr_o  = instr.r_fmt.rd;
  assign rf_we_o    = ctrl_i.rf_we;

  // load address doubles as the jalr target
  assign ld_addr  = rs1_i + imm_i;
  assign st_addr  = rs1_i + imm_s;
  assign pc_plus4 = pc_q + word_t'(4);

  always_comb begin
    case (ctrl_i.mem_addr_sel)
      ADDR_LOAD:  base_addr = ld_addr;
      ADDR_STORE: base_addr = st_addr;
      default:    base_addr = pc_q;
    endcase
  end

  assign byte_addr  = base_addr + word_t'({ctrl_i.mem_hi, 1'b0});
  assign mem_addr_o = byte_addr[`CORE_MEM_AW:1];
  assign mem_data_o = ctrl_i.mem_hi ? rs2_i[31:16] : rs2_i[15:0];
  assign mem_we_o   = ctrl_i.mem_we;

  assign alu_a_o = rs1_i;
  assign alu_b_o = ctrl_i.op2_imm ? imm_i : rs2_i;

  // bit 30 picks sub and sra, addi has no sub form
  always_comb begin
    case (instr.r_fmt.funct3)
      3'b000:  alu_op_o = (!ctrl_i.op2_imm && instr.r_fmt.funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_op_o = ALU_SLL;
      3'b010:  alu_op_o = ALU_SLT;
      3'b011:  alu_op_o = ALU_SLTU;
      3'b100:  alu_op_o = ALU_XOR;
      3'b101:  alu_op_o = instr.r_fmt.funct7[5] ? ALU_SRA : ALU_SRL;
      3'b110:  alu_op_o = ALU_OR;
      default: alu_op_o = ALU_AND;
    endcase
  end

  always_comb begin
    case (instr.b_fmt.funct3)
      3'b000:  taken = alu_flags_i.equal;
      3'b001:  taken = !alu_flags_i.equal;
      3'b100:  taken = alu_flags_i.less_signed;
      3'b101:  taken = !alu_flags_i.less_signed;
      3'b110:  taken = alu_flags_i.less;
      3'b111:  taken = !alu_flags_i.less;
      default: taken = 1'b0;
    endcase
  end

  assign pc_sel = (ctrl_i.pc_cond && !taken) ? PC_PLUS4 : ctrl_i.pc_sel;

  always_comb begin
    case (pc_sel)
      PC_JAL:    pc_next = pc_q + imm_j;
      PC_JALR:   pc_next = {ld_addr[`CORE_XLEN-1:1], 1'b0};
      PC_BRANCH: pc_next = pc_q + imm_b;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_comb begin
    case (ctrl_i.wb_sel)
      WB_IMM:  rd_data_o = ctrl_i.upper_pc ? imm_u + pc_q : imm_u;
      WB_LOAD: rd_data_o = {mem_data_i, tmp_q};
      WB_LINK: rd_data_o = pc_plus4;
      default: rd_data_o = alu_result_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q     <= '0;
      halted_q <= 1'b0;
    end else begin
      if (ctrl_i.pc_we)
        pc_q <= pc_next;
      if (ctrl_i.halt)
        halted_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.ir_lo_we)
      ir_q[15:0] <= mem_data_i;
    if (ctrl_i.ir_hi_we)
      ir_q[31:16] <= mem_data_i;
    if (ctrl_i.tmp_we)
      tmp_q <= mem_data_i;
  end

  assign halted_o = halted_q;

  a_no_fetch_write: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_i.mem_we |-> ctrl_i.mem_addr_sel != ADDR_PC && !ctrl_i.ir_lo_we)
    else $error("memory write issued during instruction fetch");

  a_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
    base_addr[1:0] == 2'b00)
    else $error("misaligned word access at %h", base_addr);

endmodule

// ==== hdl/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// register and data word width
`define CORE_XLEN 32

// halfword address width of the unified memory, 1024 halfwords
`define CORE_MEM_AW 10

// major opcode of ECALL/EBREAK, both stop the core
`define CORE_HALT_OPCODE 5'b11100

`endif

// ==== hdl/halfword_mem.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module halfword_mem (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [`CORE_MEM_AW-1:0] addr_i,
  input  logic [15:0]             data_i,
  input  logic                    we_i,
  output logic [15:0]             data_o,
  input  logic [`CORE_MEM_AW-1:0] host_addr_i,
  input  logic [15:0]             host_data_i,
  input  logic                    host_we_i
);
  localparam int DEPTH = 1 << `CORE_MEM_AW;

  logic [15:0] mem [DEPTH];

  // host preloads the program while the core sits in reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if (host_we_i)
        mem[host_addr_i] <= host_data_i;
    end else if (we_i) begin
      mem[addr_i] <= data_i;
    end
    data_o <= mem[addr_i];
  end

endmodule

// ==== hdl/isa_pkg.sv ====
`include "core_settings.svh"

package isa_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;

  // major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_IMM    = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_REG    = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYSTEM = `CORE_HALT_OPCODE
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
    logic [1:0] quad;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  quad;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
    logic [1:0] quad;
  } s_fmt_t;

  // branch offsets are scrambled so that sign bit stays at 31
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
    logic [1:0] quad;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  quad;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
    logic [1:0] quad;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef struct packed {
    logic equal;
    logic less;
    logic less_signed;
  } alu_flags_t;

endpackage

// ==== hdl/microcode_rom.sv ====
`timescale 1ns/100ps

module microcode_rom (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic [15:0]           mem_data_i,
  output ucode_pkg::ctrl_word_t ctrl_o
);
  import isa_pkg::*;
  import ucode_pkg::*;

  // table layout, execute sequences follow the two fetch entries
  localparam ucode_addr_t U_FETCH_LO = 6'd0;
  localparam ucode_addr_t U_FETCH_HI = 6'd1;
  localparam ucode_addr_t U_REG      = 6'd2;
  localparam ucode_addr_t U_IMM      = 6'd3;
  localparam ucode_addr_t U_LUI      = 6'd4;
  localparam ucode_addr_t U_AUIPC    = 6'd5;
  localparam ucode_addr_t U_BRANCH   = 6'd6;
  localparam ucode_addr_t U_JAL      = 6'd7;
  localparam ucode_addr_t U_JALR     = 6'd8;
  localparam ucode_addr_t U_LD_LO    = 6'd9;
  localparam ucode_addr_t U_LD_HI    = 6'd10;
  localparam ucode_addr_t U_LD_WB    = 6'd11;
  localparam ucode_addr_t U_ST_LO    = 6'd12;
  localparam ucode_addr_t U_ST_HI    = 6'd13;
  localparam ucode_addr_t U_HALT     = 6'd14;

  logic [2:0]  step_q;
  opcode_e     opcode_q;
  ucode_addr_t base;
  ucode_addr_t uaddr;

  function automatic ctrl_word_t ucode_entry(ucode_addr_t a);
    ctrl_word_t w;
    w = '0;
    if (a inside {U_LD_LO, U_LD_HI})
      w.mem_addr_sel = ADDR_LOAD;
    else if (a inside {U_ST_LO, U_ST_HI})
      w.mem_addr_sel = ADDR_STORE;
    w.mem_hi   = a inside {U_FETCH_HI, U_LD_HI, U_ST_HI};
    w.mem_we   = a inside {U_ST_LO, U_ST_HI};
    w.ir_lo_we = (a == U_FETCH_HI);
    // upper instruction half lands on the first execute step
    w.ir_hi_we = a inside {[U_REG:U_LD_LO], U_ST_LO};
    w.tmp_we   = (a == U_LD_HI);
    w.rf_we    = a inside {[U_REG:U_AUIPC], U_JAL, U_JALR, U_LD_WB};
    if (a inside {U_LUI, U_AUIPC})
      w.wb_sel = WB_IMM;
    else if (a inside {U_JAL, U_JALR})
      w.wb_sel = WB_LINK;
    else if (a == U_LD_WB)
      w.wb_sel = WB_LOAD;
    w.op2_imm  = (a == U_IMM);
    if (a == U_BRANCH)
      w.pc_sel = PC_BRANCH;
    else if (a == U_JAL)
      w.pc_sel = PC_JAL;
    else if (a == U_JALR)
      w.pc_sel = PC_JALR;
    w.pc_we    = a inside {[U_REG:U_JALR], U_LD_WB, U_ST_HI};
    w.pc_cond  = (a == U_BRANCH);
    w.upper_pc = (a == U_AUIPC);
    w.halt     = (a >= U_HALT);
    // every sequence ends on the step that moves the pc
    w.seq_end  = w.pc_we;
    return w;
  endfunction

  always_comb begin
    case (opcode_q)
      OP_REG:    base = U_REG;
      OP_IMM:    base = U_IMM;
      OP_LUI:    base = U_LUI;
      OP_AUIPC:  base = U_AUIPC;
      OP_BRANCH: base = U_BRANCH;
      OP_JAL:    base = U_JAL;
      OP_JALR:   base = U_JALR;
      OP_LOAD:   base = U_LD_LO;
      OP_STORE:  base = U_ST_LO;
      // system and unsupported opcodes stop the core
      default:   base = U_HALT;
    endcase
  end

  assign uaddr = (step_q < 3'd2) ? U_FETCH_LO + ucode_addr_t'(step_q)
                                 : base + ucode_addr_t'(step_q - 3'd2);
  assign ctrl_o = ucode_entry(uaddr);

  always_ff @(posedge clk_i) begin
    if (reset_i)
      step_q <= 3'd0;
    else if (ctrl_o.halt)
      step_q <= step_q;
    else if (ctrl_o.seq_end)
      step_q <= 3'd0;
    else
      step_q <= step_q + 3'd1;
  end

  // opcode sits in the lower halfword, read back during the second fetch step
  always_ff @(posedge clk_i) begin
    if (ctrl_o.ir_lo_we)
      opcode_q <= opcode_e'(mem_data_i[6:2]);
  end

  a_halt_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_o.halt |=> ctrl_o.halt && !ctrl_o.mem_we && !ctrl_o.rf_we && !ctrl_o.pc_we)
    else $error("control word left idle state after halt");

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic           clk_i,
  input  logic [4:0]     rs1_addr_i,
  input  logic [4:0]     rs2_addr_i,
  output isa_pkg::word_t rs1_o,
  output isa_pkg::word_t rs2_o,
  input  logic [4:0]     rd_addr_i,
  input  isa_pkg::word_t rd_data_i,
  input  logic           we_i,
  input  logic [4:0]     dbg_addr_i,
  output isa_pkg::word_t dbg_data_o
);
  import isa_pkg::*;

  word_t regs [32];

  // x0 reads as zero, its storage is never written
  function automatic word_t read_reg(logic [4:0] addr);
    return (addr == 5'd0) ? '0 : regs[addr];
  endfunction

  assign rs1_o      = read_reg(rs1_addr_i);
  assign rs2_o      = read_reg(rs2_addr_i);
  assign dbg_data_o = read_reg(dbg_addr_i);

  always_ff @(posedge clk_i) begin
    if (we_i && rd_addr_i != 5'd0)
      regs[rd_addr_i] <= rd_data_i;
  end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module rv_core_top (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic [`CORE_MEM_AW-1:0] host_addr_i,
  input  logic [15:0]             host_data_i,
  input  logic                    host_we_i,
  input  logic [4:0]              dbg_addr_i,
  output isa_pkg::word_t          dbg_data_o,
  output logic                    halted_o
);
  import isa_pkg::*;
  import ucode_pkg::*;

  ctrl_word_t              ctrl;
  logic [`CORE_MEM_AW-1:0] mem_addr;
  logic [15:0]             mem_wdata;
  logic [15:0]             mem_rdata;
  logic                    mem_we;
  logic [4:0]              rs1_addr;
  logic [4:0]              rs2_addr;
  logic [4:0]              rd_addr;
  logic                    rf_we;
  word_t                   rs1;
  word_t                   rs2;
  word_t                   rd_data;
  alu_op_e                 alu_op;
  word_t                   alu_a;
  word_t                   alu_b;
  word_t                   alu_result;
  alu_flags_t              alu_flags;

  microcode_rom i_ucode (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .mem_data_i (mem_rdata),
    .ctrl_o     (ctrl)
  );

  control_unit i_ctrl (
    .clk_i, .reset_i,
    .ctrl_i       (ctrl),
    .mem_data_i   (mem_rdata),
    .mem_addr_o   (mem_addr),
    .mem_data_o   (mem_wdata),
    .mem_we_o     (mem_we),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rd_addr_o    (rd_addr),
    .rf_we_o      (rf_we),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .rd_data_o    (rd_data),
    .alu_op_o     (alu_op),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_result_i (alu_result),
    .alu_flags_i  (alu_flags),
    .halted_o     (halted_o)
  );

  alu i_alu (
    .op_i     (alu_op),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .result_o (alu_result),
    .flags_o  (alu_flags)
  );

  reg_file i_rf (
    .clk_i      (clk_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rd_addr_i  (rd_addr),
    .rd_data_i  (rd_data),
    .we_i       (rf_we),
    .dbg_addr_i (dbg_addr_i),
    .dbg_data_o (dbg_data_o)
  );

  halfword_mem i_mem (
    .clk_i, .reset_i,
    .addr_i      (mem_addr),
    .data_i      (mem_wdata),
    .we_i        (mem_we),
    .data_o      (mem_rdata),
    .host_addr_i (host_addr_i),
    .host_data_i (host_data_i),
    .host_we_i   (host_we_i)
  );

endmodule

// ==== hdl/ucode_pkg.sv ====
package ucode_pkg;

  typedef logic [5:0] ucode_addr_t;

  typedef enum logic [1:0] {
    ADDR_PC,
    ADDR_LOAD,
    ADDR_STORE
  } addr_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_IMM,
    WB_LOAD,
    WB_LINK
  } wb_sel_e;

  typedef enum logic [1:0] {
    PC_PLUS4,
    PC_JAL,
    PC_JALR,
    PC_BRANCH
  } pc_sel_e;

  // one microcode step, 32 bits
  typedef struct packed {
    logic [13:0] spare;
    addr_sel_e   mem_addr_sel;
    logic        mem_hi;
    logic        mem_we;
    logic        ir_lo_we;
    logic        ir_hi_we;
    logic        tmp_we;
    logic        rf_we;
    wb_sel_e     wb_sel;
    logic        op2_imm;
    pc_sel_e     pc_sel;
    logic        pc_we;
    logic        pc_cond;   // branch target only when the compare holds
    logic        upper_pc;  // add pc to the upper immediate
    logic        halt;
    logic        seq_end;
  } ctrl_word_t;

endpackage
